// ==== Makefile ====
# Verilator simulation of the AXI4 write master

sim:
	verilator --binary --timing --assert --top-module wm_tb -Mdir obj_dir -f all.f
	./obj_dir/Vwm_tb > sim.log 2>&1; cat sim.log
	! grep -q "Something failed" sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== all.f ====
+incdir+verilog
verilog/wm_pkg.sv
verilog/wm_cmd_setup.sv
verilog/wm_data_beat.sv
verilog/wm_addr_issue.sv
verilog/wm_resp_track.sv
verilog/wm_write_master.sv
bench/wm_asserts.sv
bench/wm_tb.sv

// ==== bench/wm_asserts.sv ====
// Handshake and pulse checks on the write master ports
// Attached to every wm_write_master by the bind at the end
`timescale 1ns/1ps

module wm_asserts (
  input logic           aclk,
  input logic           areset,
  input logic           m_axi_awvalid,
  input logic           m_axi_awready,
  input wm_pkg::wm_aw_t m_axi_aw,
  input logic           m_axi_wvalid,
  input logic           m_axi_wready,
  input wm_pkg::wm_w_t  m_axi_w,
  input logic           ctrl_done
);

  ////////////////////////////////////////
  // Valid holds until taken
  ////////////////////////////////////////
  aw_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid)
    else $error("AW valid dropped before its handshake");

  w_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid)
    else $error("W valid dropped before its handshake");

  ////////////////////////////////////////
  // Payload stable under stall
  ////////////////////////////////////////
  aw_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_awvalid && !m_axi_awready |=> $stable(m_axi_aw))
    else $error("AW payload changed while stalled");

  w_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_wvalid && !m_axi_wready |=> $stable(m_axi_w))
    else $error("W payload changed while stalled");

  // Completion is a single-cycle pulse
  done_pulse: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else $error("ctrl_done held longer than one cycle");

endmodule

bind wm_write_master wm_asserts u_asserts (.*);

// ==== bench/wm_tb.sv ====
// Directed testbench for the AXI4 write master with a simple memory slave
// Runs six transfer tests and prints one line per test, then a summary
`timescale 1ns/1ps
`include "wm_consts.svh"

module wm_tb;

  import wm_pkg::*;

  logic                  aclk             = 1'b0;
  logic                  areset           = 1'b1;
  logic                  ctrl_start       = 1'b0;
  logic [`WM_ADDR_W-1:0] ctrl_addr_offset = '0;
  logic [`WM_XFER_W-1:0] ctrl_xfer_size   = '0;
  logic                  ctrl_done;
  logic                  s_axis_tvalid    = 1'b0;
  logic                  s_axis_tready;
  logic [`WM_DATA_W-1:0] s_axis_tdata     = 32'h0001_0000;
  logic                  m_axi_awvalid;
  logic                  m_axi_awready    = 1'b0;
  wm_aw_t                m_axi_aw;
  logic                  m_axi_wvalid;
  logic                  m_axi_wready     = 1'b0;
  wm_w_t                 m_axi_w;
  logic                  m_axi_bvalid     = 1'b0;
  logic                  m_axi_bready;

  // Slave records and bookkeeping
  wm_aw_t      aw_q[$];
  wm_w_t       w_q[$];
  logic [31:0] mem [logic [31:0]];
  int          aw_cnt    = 0;
  int          w_cnt     = 0;
  int          wlast_cnt = 0;
  int          b_raised  = 0;
  int          done_cnt  = 0;
  int          bready_low = 0;
  int          aw_base, w_base, done_base;
  logic [31:0] first_word;
  int          errors    = 0;
  int          tests     = 0;
  // Stimulus control
  logic        stall_en   = 1'b0;
  logic        holdb      = 1'b0;
  logic        src_pause  = 1'b0;
  logic        stream_go  = 1'b0;
  int          stream_req = 0;
  int          stream_left = 0;
  logic [31:0] lfsr       = 32'h59e8_2038;

  wm_write_master UUT (.*);

  always #20 aclk = ~aclk;

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  ////////////////////////////////////////
  // Ready and pause generation
  ////////////////////////////////////////
  always @(posedge aclk) begin : ready_gen
    if (areset) begin
      m_axi_awready <= 1'b0;
      m_axi_wready  <= 1'b0;
      src_pause     <= 1'b0;
    end else if (stall_en) begin
      // One LFSR step per bit taken
      lfsr = lfsr_step(lfsr);
      m_axi_awready <= lfsr[0];
      lfsr = lfsr_step(lfsr);
      m_axi_wready <= lfsr[0];
      lfsr = lfsr_step(lfsr);
      src_pause <= lfsr[0];
    end else begin
      m_axi_awready <= 1'b1;
      m_axi_wready  <= 1'b1;
      src_pause     <= 1'b0;
    end
  end

  // Stream source, incrementing word, beat held until taken
  always @(posedge aclk) begin : stream_drive
    logic taken;
    int   left;
    taken = s_axis_tvalid & s_axis_tready;
    left  = stream_go ? stream_req : stream_left - (taken ? 1 : 0);
    stream_left <= left;
    if (taken) begin
      s_axis_tdata <= s_axis_tdata + 32'd1;
    end
    if (areset) begin
      s_axis_tvalid <= 1'b0;
    end else if (!s_axis_tvalid || taken) begin
      s_axis_tvalid <= (left > 0) && !src_pause;
    end
  end

  ////////////////////////////////////////
  // Memory slave
  ////////////////////////////////////////
  always @(posedge aclk) begin : slave
    int b_ready;
    b_ready = (aw_cnt < wlast_cnt) ? aw_cnt : wlast_cnt;
    if (m_axi_awvalid && m_axi_awready) begin
      aw_q.push_back(m_axi_aw);
      aw_cnt <= aw_cnt + 1;
    end
    if (m_axi_wvalid && m_axi_wready) begin
      w_q.push_back(m_axi_w);
      w_cnt <= w_cnt + 1;
      if (m_axi_w.last) begin
        wlast_cnt <= wlast_cnt + 1;
      end
    end
    // B only once both the address and WLAST of a burst are in
    if (areset) begin
      m_axi_bvalid <= 1'b0;
    end else if ((!m_axi_bvalid || m_axi_bready) && !holdb && b_raised < b_ready) begin
      m_axi_bvalid <= 1'b1;
      b_raised     <= b_raised + 1;
    end else if (m_axi_bvalid && m_axi_bready) begin
      m_axi_bvalid <= 1'b0;
    end
    // Cycles out of reset with bready low
    if (!areset && m_axi_bready !== 1'b1) begin
      bready_low <= bready_low + 1;
    end
    if (ctrl_done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_aw(input wm_aw_t got, input wm_aw_t exp);
    if (got !== exp) begin
      errors++;
      $display("error m_axi_aw got addr %h len %h expected addr %h len %h",
               got.addr, got.len, exp.addr, exp.len);
    end
  endtask

  task automatic check_w(input int beat, input wm_w_t got, input wm_w_t exp);
    if (got !== exp) begin
      errors++;
      $display("error m_axi_w beat %0d got %h/%h/%h expected %h/%h/%h", beat,
               got.data, got.strb, got.last, exp.data, exp.strb, exp.last);
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("error ctrl_done got %h expected %h", got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("error %s count got %h expected %h", what, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] addr, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error mem[%h] got %h expected %h", addr, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Sequencing helpers
  ////////////////////////////////////////
  task automatic timed_out(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic launch(input logic [31:0] addr, input int bytes);
    @(posedge aclk);
    stream_req <= (bytes + 3) / 4;
    stream_go  <= 1'b1;
    @(posedge aclk);
    stream_go <= 1'b0;
    aw_base    = aw_cnt;
    w_base     = w_cnt;
    done_base  = done_cnt;
    first_word = s_axis_tdata;
    ctrl_addr_offset <= addr;
    ctrl_xfer_size   <= 16'(bytes);
    ctrl_start       <= 1'b1;
    @(posedge aclk);
    ctrl_start <= 1'b0;
  endtask

  // Waits for the pulse, then checks it is gone a cycle later
  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (ctrl_done !== 1'b1 && n < limit) begin
      @(posedge aclk);
      n++;
    end
    if (ctrl_done !== 1'b1) begin
      timed_out("ctrl_done");
    end else begin
      @(posedge aclk);
      check_done(ctrl_done, 1'b0);
    end
  endtask

  task automatic wait_beats(input int beats, input int limit);
    int n;
    n = 0;
    while (w_cnt - w_base < beats && n < limit) begin
      @(posedge aclk);
      n++;
    end
    if (w_cnt - w_base < beats) begin
      timed_out("the W beats");
    end
  endtask

  // Expected bursts from the size rules, 1 KB alignment and 256-beat bursts
  task automatic check_transfer(input logic [31:0] addr, input int bytes);
    int          beats;
    int          nb;
    int          rem;
    logic [31:0] base;
    logic [31:0] a;
    wm_aw_t      exp_aw;
    wm_w_t       exp_w;
    beats = (bytes + 3) / 4;
    nb    = (beats + `WM_BURST_LEN - 1) / `WM_BURST_LEN;
    rem   = bytes % `WM_STRB_W;
    base  = addr & ~32'(`WM_BURST_BYTES - 1);
    check_count("AW handshake", aw_cnt - aw_base, nb);
    check_count("W beat", w_cnt - w_base, beats);
    check_count("ctrl_done pulse", done_cnt - done_base, 1);
    check_count("m_axi_bready low cycle", bready_low, 0);
    if (aw_cnt - aw_base == nb && w_cnt - w_base == beats) begin
      for (int i = 0; i < nb; i++) begin
        exp_aw.addr = base + 32'(i * `WM_BURST_BYTES);
        exp_aw.len  = (i == nb - 1) ? 8'(beats - 1 - `WM_BURST_LEN * i) : 8'd255;
        check_aw(aw_q[aw_base + i], exp_aw);
      end
      mem.delete();
      for (int k = 0; k < beats; k++) begin
        exp_w.data = first_word + 32'(k);
        exp_w.strb = (k == beats - 1 && rem != 0) ? 4'hf >> (4 - rem) : 4'hf;
        exp_w.last = (k % `WM_BURST_LEN == `WM_BURST_LEN - 1) || (k == beats - 1);
        check_w(k, w_q[w_base + k], exp_w);
        // Place the beat at its burst address in the memory model
        a = aw_q[aw_base + k / `WM_BURST_LEN].addr + 32'(4 * (k % `WM_BURST_LEN));
        mem[a] = w_q[w_base + k].data;
      end
      for (int k = 0; k < beats; k++) begin
        a = base + 32'(4 * k);
        check_word(a, mem[a], first_word + 32'(k));
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("%s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic run_plain(input string name, input logic [31:0] addr, input int bytes);
    int e0;
    e0 = errors;
    launch(addr, bytes);
    wait_done(20000);
    check_transfer(addr, bytes);
    report_test(name, e0);
  endtask

  task automatic test_stalls();
    int e0;
    e0 = errors;
    stall_en <= 1'b1;
    // 537 beats, three bursts
    launch(32'h5000, 2148);
    wait_done(40000);
    stall_en <= 1'b0;
    check_transfer(32'h5000, 2148);
    report_test("random stalls", e0);
  endtask

  task automatic test_outstanding();
    int e0;
    e0 = errors;
    holdb <= 1'b1;
    launch(32'h8000, 6144);
    wait_beats(1536, 20000);
    // Short window for any late AW
    repeat (8) @(posedge aclk);
    check_count("AW with B held", aw_cnt - aw_base, `WM_MAX_OUTSTANDING);
    holdb <= 1'b0;
    wait_done(20000);
    check_transfer(32'h8000, 6144);
    report_test("outstanding limit", e0);
  endtask

  initial begin : main
    repeat (4) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    run_plain("single burst", 32'h1000, 64);
    run_plain("partial last beat", 32'h1400, 30);
    run_plain("multi burst", 32'h2000, 2500);
    run_plain("address alignment", 32'h3123, 40);
    test_stalls();
    test_outstanding();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== verilog/wm_addr_issue.sv ====
// Issues one AW request for every burst whose data has started
// Addresses step by a full burst; the last burst gets the short length
`timescale 1ns/1ps
`include "wm_consts.svh"

module wm_addr_issue (
  input  logic             aclk,
  input  logic             areset,
  input  wm_pkg::wm_plan_t plan,
  input  logic             start,
  input  logic             first_beat_pulse,
  input  logic             room,
  output logic             m_axi_awvalid,
  input  logic             m_axi_awready,
  output wm_pkg::wm_aw_t   m_axi_aw,
  output logic             aw_fire
);

  // Bursts with data under way but no address yet
  logic [`WM_TXN_W:0]    pending;
  logic [`WM_TXN_W-1:0]  aw_left;
  logic [`WM_ADDR_W-1:0] addr;

  ////////////////////////////////////////
  // AW handshake
  ////////////////////////////////////////
  // room only falls on aw_fire, so a raised awvalid holds until taken
  assign m_axi_awvalid = (pending != '0) & room;
  assign aw_fire       = m_axi_awvalid & m_axi_awready;

  always_ff @(posedge aclk) begin
    if (areset) begin
      pending <= '0;
    end else begin
      case ({first_beat_pulse, aw_fire})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  ////////////////////////////////////////
  // Address and length
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (start) begin
      addr <= plan.addr;
    end else if (aw_fire) begin
      addr <= addr + `WM_ADDR_W'(`WM_BURST_BYTES);
    end
  end

  // Address requests left, zero on the final burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_left <= '0;
    end else if (start) begin
      aw_left <= plan.num_txn;
    end else if (aw_fire) begin
      aw_left <= aw_left - 1'b1;
    end
  end

  assign m_axi_aw.addr = addr;
  assign m_axi_aw.len  = (aw_left == '0) ? plan.final_len :
                         `WM_LOG_BURST_LEN'(`WM_BURST_LEN - 1);

endmodule

// ==== verilog/wm_cmd_setup.sv ====
// Captures a write request and turns it into a burst plan
// start pulses once the plan is stable, two cycles after ctrl_start
`timescale 1ns/1ps
`include "wm_consts.svh"

module wm_cmd_setup (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  ctrl_start,
  input  logic [`WM_ADDR_W-1:0] ctrl_addr_offset,
  input  logic [`WM_XFER_W-1:0] ctrl_xfer_size,
  output wm_pkg::wm_plan_t      plan,
  output logic                  start
);

  import wm_pkg::*;

  wm_cmd_t   cmd;
  wm_phase_e phase;
  logic      load_cmd;
  logic [`WM_XFER_W-`WM_LOG_DW_BYTES-1:0] size_beats;

  ////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////
  // A new request is ignored only while the previous one is loading
  assign load_cmd   = ctrl_start & (phase != PH_LOAD);
  assign size_beats = ctrl_xfer_size[`WM_XFER_W-1:`WM_LOG_DW_BYTES];

  always_ff @(posedge aclk) begin
    if (load_cmd) begin
      // Drop the low bits so no burst straddles a 1 KB line
      cmd.addr      <= ctrl_addr_offset & ~(`WM_ADDR_W'(`WM_BURST_BYTES - 1));
      // Round up to whole beats, stored as length minus one
      cmd.total_len <= (ctrl_xfer_size[`WM_LOG_DW_BYTES-1:0] != '0) ?
                       size_beats : size_beats - 1'b1;
      // Zero remainder wraps to all ones, a full last beat
      cmd.byte_rem  <= ctrl_xfer_size[`WM_LOG_DW_BYTES-1:0] - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      phase <= PH_IDLE;
      start <= 1'b0;
    end else begin
      start <= 1'b0;
      case (phase)
        PH_IDLE: begin
          if (load_cmd) begin
            phase <= PH_LOAD;
          end
        end
        PH_LOAD: begin
          // Command now stored, release the other stages
          phase <= PH_RUN;
          start <= 1'b1;
        end
        PH_RUN: begin
          if (load_cmd) begin
            phase <= PH_LOAD;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Burst plan
  ////////////////////////////////////////
  always_comb begin
    plan.addr      = cmd.addr;
    // Upper beat bits count whole bursts, lower bits the final one
    plan.num_txn   = cmd.total_len[`WM_LOG_BURST_LEN +: `WM_TXN_W];
    plan.final_len = cmd.total_len[`WM_LOG_BURST_LEN-1:0];
    plan.single    = (cmd.total_len[`WM_LOG_BURST_LEN +: `WM_TXN_W] == '0);
    // Keep bytes up to the remainder in the very last beat
    for (int i = 0; i < `WM_STRB_W; i++) begin
      plan.final_strb[i] = (i <= int'(cmd.byte_rem));
    end
  end

endmodule

// ==== verilog/wm_consts.svh ====
// Width and limit constants for the AXI4 write master
// Include wherever a bus, counter or burst limit is sized
`ifndef WM_CONSTS_SVH
`define WM_CONSTS_SVH

// Bus widths
`define WM_ADDR_W 32
`define WM_DATA_W 32
`define WM_STRB_W 4
`define WM_LOG_DW_BYTES 2

// Request size in bytes
`define WM_XFER_W 16

// Burst shape, 256 beats of 4 bytes
`define WM_BURST_LEN 256
`define WM_LOG_BURST_LEN 8
`define WM_BURST_BYTES 1024
`define WM_TXN_W 6

// Bursts allowed in flight without a B
`define WM_MAX_OUTSTANDING 4
`define WM_OUTST_W 3

`endif

// ==== verilog/wm_data_beat.sv ====
// Passes stream beats onto the AXI W channel while a transfer runs
// Produces WLAST per burst, the trimmed final strobe and a first-beat pulse
`timescale 1ns/1ps
`include "wm_consts.svh"

module wm_data_beat (
  input  logic                  aclk,
  input  logic                  areset,
  input  wm_pkg::wm_plan_t      plan,
  input  logic                  start,
  input  logic                  s_axis_tvalid,
  input  logic [`WM_DATA_W-1:0] s_axis_tdata,
  output logic                  s_axis_tready,
  output logic                  m_axi_wvalid,
  input  logic                  m_axi_wready,
  output wm_pkg::wm_w_t         m_axi_w,
  output logic                  first_beat_pulse
);

  logic                         running;
  logic                         wxfer;
  logic                         final_burst;
  logic                         almost_final;
  logic                         final_xfer;
  logic [`WM_LOG_BURST_LEN-1:0] beats_left;
  logic [`WM_TXN_W-1:0]         bursts_left;
  logic                         wfirst;
  logic                         first_seen;

  ////////////////////////////////////////
  // Stream to W pass-through
  ////////////////////////////////////////
  // Nothing moves until the size of the transfer is known
  assign m_axi_wvalid  = s_axis_tvalid & running;
  assign s_axis_tready = m_axi_wready & running;
  assign wxfer         = m_axi_wvalid & m_axi_wready;

  assign m_axi_w.data = s_axis_tdata;
  assign m_axi_w.last = (beats_left == '0);
  // Partial strobe only on the closing beat of the transfer
  assign m_axi_w.strb = (m_axi_w.last & final_burst) ? plan.final_strb : '1;

  assign final_burst  = (bursts_left == '0);
  assign almost_final = (bursts_left == `WM_TXN_W'(1));
  assign final_xfer   = wxfer & m_axi_w.last & final_burst;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (final_xfer) begin
      running <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Beat and burst counters
  ////////////////////////////////////////
  // Beats left in the current burst, zero means WLAST
  always_ff @(posedge aclk) begin
    if (areset) begin
      beats_left <= '1;
    end else if (start) begin
      beats_left <= plan.single ? plan.final_len : '1;
    end else if (wxfer) begin
      if (m_axi_w.last & almost_final) begin
        // Next burst is the short one
        beats_left <= plan.final_len;
      end else begin
        // Wraps to a full burst after WLAST
        beats_left <= beats_left - 1'b1;
      end
    end
  end

  // Bursts still to close, zero on the final burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (start) begin
      bursts_left <= plan.num_txn;
    end else if (wxfer & m_axi_w.last) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  ////////////////////////////////////////
  // First beat of each burst
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst           <= 1'b1;
      first_seen       <= 1'b0;
      first_beat_pulse <= 1'b0;
    end else begin
      // Beat after WLAST opens a new burst, also for 1-beat bursts
      if (wxfer) begin
        wfirst <= m_axi_w.last;
      end
      if (wxfer) begin
        first_seen <= 1'b0;
      end else if (m_axi_wvalid & wfirst) begin
        first_seen <= 1'b1;
      end
      // One pulse per burst even if the first beat stalls
      first_beat_pulse <= m_axi_wvalid & wfirst & ~first_seen;
    end
  end

endmodule

// ==== verilog/wm_pkg.sv ====
// Shared types of the write master stages
// Compile before any stage that names these structs
package wm_pkg;

  `include "wm_consts.svh"

  // Request as captured on ctrl_start
  typedef struct packed {
    logic [`WM_ADDR_W-1:0]                  addr;       // Burst aligned
    logic [`WM_XFER_W-`WM_LOG_DW_BYTES-1:0] total_len;  // Beats minus one
    logic [`WM_LOG_DW_BYTES-1:0]            byte_rem;   // Bytes in last beat minus one
  } wm_cmd_t;

  // Burst plan seen by the three downstream stages
  typedef struct packed {
    logic [`WM_ADDR_W-1:0]        addr;
    logic [`WM_TXN_W-1:0]         num_txn;     // Bursts minus one
    logic [`WM_LOG_BURST_LEN-1:0] final_len;   // Last burst beats minus one
    logic [`WM_STRB_W-1:0]        final_strb;
    logic                         single;
  } wm_plan_t;

  // W channel payload
  typedef struct packed {
    logic [`WM_DATA_W-1:0] data;
    logic [`WM_STRB_W-1:0] strb;
    logic                  last;
  } wm_w_t;

  // AW channel payload
  typedef struct packed {
    logic [`WM_ADDR_W-1:0]        addr;
    logic [`WM_LOG_BURST_LEN-1:0] len;
  } wm_aw_t;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_LOAD,
    PH_RUN
  } wm_phase_e;

endpackage

// ==== verilog/wm_resp_track.sv ====
// Accepts B responses, caps bursts in flight and signals completion
// ctrl_done pulses the cycle after the final B handshake
`timescale 1ns/1ps
`include "wm_consts.svh"

module wm_resp_track (
  input  logic             aclk,
  input  logic             areset,
  input  wm_pkg::wm_plan_t plan,
  input  logic             start,
  input  logic             aw_fire,
  input  logic             m_axi_bvalid,
  output logic             m_axi_bready,
  output logic             room,
  output logic             ctrl_done
);

  logic                   bfire;
  logic [`WM_OUTST_W-1:0] vacancy;
  logic [`WM_TXN_W-1:0]   b_left;

  // Responses are never back-pressured
  assign m_axi_bready = 1'b1;
  assign bfire        = m_axi_bvalid & m_axi_bready;

  ////////////////////////////////////////
  // Outstanding limit
  ////////////////////////////////////////
  // Free slots for bursts awaiting B
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= `WM_OUTST_W'(`WM_MAX_OUTSTANDING);
    end else begin
      case ({aw_fire, bfire})
        2'b10:   vacancy <= vacancy - 1'b1;
        2'b01:   vacancy <= vacancy + 1'b1;
        default: vacancy <= vacancy;
      endcase
    end
  end

  assign room = (vacancy != '0);

  ////////////////////////////////////////
  // Completion
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      b_left    <= '0;
      ctrl_done <= 1'b0;
    end else begin
      if (start) begin
        b_left <= plan.num_txn;
      end else if (bfire) begin
        b_left <= b_left - 1'b1;
      end
      // Zero count means this B closes the last burst
      ctrl_done <= bfire & (b_left == '0);
    end
  end

endmodule

// ==== verilog/wm_write_master.sv ====
// AXI4 write master fed by an AXI4-Stream, top level of the design
// Load address and size with ctrl_start, wait for the ctrl_done pulse
`timescale 1ns/1ps
`include "wm_consts.svh"

module wm_write_master (
  input  logic                  aclk,
  input  logic                  areset,
  // Control
  input  logic                  ctrl_start,
  input  logic [`WM_ADDR_W-1:0] ctrl_addr_offset,
  input  logic [`WM_XFER_W-1:0] ctrl_xfer_size,
  output logic                  ctrl_done,
  // Stream in
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic [`WM_DATA_W-1:0] s_axis_tdata,
  // AXI write address
  output logic                  m_axi_awvalid,
  input  logic                  m_axi_awready,
  output wm_pkg::wm_aw_t        m_axi_aw,
  // AXI write data
  output logic                  m_axi_wvalid,
  input  logic                  m_axi_wready,
  output wm_pkg::wm_w_t         m_axi_w,
  // AXI write response
  input  logic                  m_axi_bvalid,
  output logic                  m_axi_bready
);

  import wm_pkg::*;

  wm_plan_t plan;
  logic     start;
  logic     first_beat_pulse;
  logic     aw_fire;
  logic     room;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////
  wm_cmd_setup u_cmd_setup (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .plan             (plan),
    .start            (start)
  );

  wm_data_beat u_data_beat (
    .aclk             (aclk),
    .areset           (areset),
    .plan             (plan),
    .start            (start),
    .s_axis_tvalid    (s_axis_tvalid),
    .s_axis_tdata     (s_axis_tdata),
    .s_axis_tready    (s_axis_tready),
    .m_axi_wvalid     (m_axi_wvalid),
    .m_axi_wready     (m_axi_wready),
    .m_axi_w          (m_axi_w),
    .first_beat_pulse (first_beat_pulse)
  );

  // Address follows data, throttled by the response tracker
  wm_addr_issue u_addr_issue (
    .aclk             (aclk),
    .areset           (areset),
    .plan             (plan),
    .start            (start),
    .first_beat_pulse (first_beat_pulse),
    .room             (room),
    .m_axi_awvalid    (m_axi_awvalid),
    .m_axi_awready    (m_axi_awready),
    .m_axi_aw         (m_axi_aw),
    .aw_fire          (aw_fire)
  );

  wm_resp_track u_resp_track (
    .aclk         (aclk),
    .areset       (areset),
    .plan         (plan),
    .start        (start),
    .aw_fire      (aw_fire),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .room         (room),
    .ctrl_done    (ctrl_done)
  );

endmodule
